// ==== hdl/clk_gate_ctrl.sv ====
/*
 * Pipeline clock control: enable register driven by
 * sleep/wake strobes and a latch-based clock gate
 */
module clk_gate_ctrl
    import rst_pkg::*;
    import clk_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  rst_test_s  i_test,
    input  clk_sleep_s i_sleep,
    output logic       o_clk_pipe,
    output logic       o_clk_pipe_en
);

    logic pipe_en_ff;
    logic pipe_en;
    logic pipe_en_latch;

    // ------------------------------------------------------------------
    // Enable register
    // ------------------------------------------------------------------

    // Pipeline runs out of reset; wake has priority over sleep
    always_ff @(posedge i_clk, negedge i_rst_n)
    begin
        if (!i_rst_n)
            pipe_en_ff <= 1'b1;
        else if (i_sleep.wake)
            pipe_en_ff <= 1'b1;
        else if (i_sleep.sleep)
            pipe_en_ff <= 1'b0;
    end

    // Scan clocking must never be stopped
    assign pipe_en       = pipe_en_ff | i_test.test_mode;
    assign o_clk_pipe_en = pipe_en;

    // ------------------------------------------------------------------
    // Clock gate
    // ------------------------------------------------------------------

    // Transparent in the low phase, so the enable is stable
    // for the whole high phase
    always_latch
    begin
        if (!i_clk)
            pipe_en_latch = pipe_en;
    end

    assign o_clk_pipe = i_clk & pipe_en_latch;

endmodule : clk_gate_ctrl

// ==== hdl/clk_pkg.sv ====
/*
 * Clock control types: sleep and wake strobes
 * for the pipeline clock gate
 */
package clk_pkg;

    // ------------------------------------------------------------------
    // Pipeline sleep control
    // ------------------------------------------------------------------

    // One-cycle strobes, sampled on the rising clock edge.
    // Wake wins when both are high in the same cycle.
    typedef struct packed {
        logic sleep;
        logic wake;
    } clk_sleep_s;

endpackage : clk_pkg

// ==== hdl/core_ctrl_config.svh ====
/*
 * Build-time options of the core reset and clock control block
 */

`ifndef CORE_CTRL_CONFIG_SVH
`define CORE_CTRL_CONFIG_SVH

// ----------------------------------------------------------------------
// Reset synchronizers
// ----------------------------------------------------------------------

// Flip-flops per reset synchronizer, at least 2
`define CORE_RST_SYNC_STAGES 2

// 1 when reset inputs already come synchronous to clk
`define CORE_RST_INPUTS_SYNC 0

`endif

// ==== hdl/core_ctrl_top.sv ====
/*
 * Core reset and clock control top: reset unit
 * and pipeline clock gate
 */
module core_ctrl_top
    import rst_pkg::*;
    import clk_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  rst_in_s    i_rst_in,
    input  rst_test_s  i_test,
    input  clk_sleep_s i_sleep,
    output core_rst_s  o_core_rst,
    output logic       o_clk_pipe,
    output logic       o_clk_pipe_en
);

    // Synchronized system reset for the clock gate
    logic sys_rst_n;

    // ------------------------------------------------------------------
    // Reset generation
    // ------------------------------------------------------------------
    rst_ctrl_unit i_rst_ctrl (
        .i_clk       (clk),
        .i_arst_n    (i_arst_n),
        .i_rst_in    (i_rst_in),
        .i_test      (i_test),
        .o_core_rst  (o_core_rst),
        .o_sys_rst_n (sys_rst_n)
    );

    // ------------------------------------------------------------------
    // Pipeline clock gating
    // ------------------------------------------------------------------
    clk_gate_ctrl i_clk_gate (
        .i_clk         (clk),
        .i_rst_n       (sys_rst_n),
        .i_test        (i_test),
        .i_sleep       (i_sleep),
        .o_clk_pipe    (o_clk_pipe),
        .o_clk_pipe_en (o_clk_pipe_en)
    );

endmodule : core_ctrl_top

// ==== hdl/rst_buf_qlfy_cell.sv ====
/*
 * Core reset buffer with release qualifier
 */
module rst_buf_qlfy_cell
    import rst_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  rst_test_s i_test,
    input  logic      i_rst_n,
    output core_rst_s o_core_rst
);

    logic arst_n;
    logic rst_ff;
    logic qlfy_ff;

    assign arst_n = i_test.test_mode ? i_test.test_rst_n : i_arst_n;

    // qlfy_ff trails the buffered reset by one cycle
    always_ff @(posedge i_clk, negedge arst_n)
    begin
        if (!arst_n)
        begin
            rst_ff  <= 1'b0;
            qlfy_ff <= 1'b0;
        end
        else
        begin
            rst_ff  <= i_rst_n;
            qlfy_ff <= rst_ff;
        end
    end

    // Release is registered, assertion passes through at once
    always_comb
    begin
        if (i_test.test_mode)
        begin
            o_core_rst.rst_n = i_test.test_rst_n;
            o_core_rst.qlfy  = i_test.test_rst_n;
        end
        else
        begin
            o_core_rst.rst_n = rst_ff & i_rst_n;
            o_core_rst.qlfy  = qlfy_ff & i_rst_n;
        end
    end

endmodule : rst_buf_qlfy_cell

// ==== hdl/rst_ctrl_unit.sv ====
/*
 * Reset control: input synchronizers (or bypass) and
 * core reset generation from system and CPU resets
 */
`include "core_ctrl_config.svh"

module rst_ctrl_unit
    import rst_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  rst_in_s   i_rst_in,
    input  rst_test_s i_test,
    output core_rst_s o_core_rst,
    output logic      o_sys_rst_n
);

    logic pwrup_rst_n_sync;
    logic sys_rst_n_sync;
    logic cpu_rst_n_sync;
    logic core_rst_n_sync;

    // ------------------------------------------------------------------
    // Reset input conditioning
    // ------------------------------------------------------------------
    generate
        if (`CORE_RST_INPUTS_SYNC != 0)
        begin : gen_rst_inputs_sync
            // Inputs already synchronous, only the test mux remains
            assign pwrup_rst_n_sync = i_test.test_mode ? i_test.test_rst_n : i_arst_n;
            assign sys_rst_n_sync   = i_test.test_mode ? i_test.test_rst_n : i_rst_in.rst_n;
            assign cpu_rst_n_sync   = i_test.test_mode ? i_test.test_rst_n : i_rst_in.cpu_rst_n;
        end
        else
        begin : gen_rst_inputs_async
            rst_sync_cell i_pwrup_rst_sync (
                .i_clk    (i_clk),
                .i_arst_n (i_arst_n),
                .i_test   (i_test),
                .o_rst_n  (pwrup_rst_n_sync)
            );

            rst_sync_cell i_sys_rst_sync (
                .i_clk    (i_clk),
                .i_arst_n (i_rst_in.rst_n),
                .i_test   (i_test),
                .o_rst_n  (sys_rst_n_sync)
            );

            rst_sync_cell i_cpu_rst_sync (
                .i_clk    (i_clk),
                .i_arst_n (i_rst_in.cpu_rst_n),
                .i_test   (i_test),
                .o_rst_n  (cpu_rst_n_sync)
            );
        end
    endgenerate

    // ------------------------------------------------------------------
    // Core reset
    // ------------------------------------------------------------------
    assign core_rst_n_sync = sys_rst_n_sync & cpu_rst_n_sync;

    rst_buf_qlfy_cell i_core_rst_buf (
        .i_clk      (i_clk),
        .i_arst_n   (pwrup_rst_n_sync),
        .i_test     (i_test),
        .i_rst_n    (core_rst_n_sync),
        .o_core_rst (o_core_rst)
    );

    assign o_sys_rst_n = sys_rst_n_sync;

endmodule : rst_ctrl_unit

// ==== hdl/rst_pkg.sv ====
/*
 * Reset types: external reset inputs, test-mode controls
 * and the buffered core reset with its qualifier
 */
package rst_pkg;

    // External reset requests, both active low
    typedef struct packed {
        logic rst_n;
        logic cpu_rst_n;
    } rst_in_s;

    // Scan test controls
    typedef struct packed {
        logic test_mode;
        logic test_rst_n;
    } rst_test_s;

    // Generated core reset
    typedef struct packed {
        logic rst_n;
        logic qlfy;   // released and stable for at least one cycle
    } core_rst_s;

endpackage : rst_pkg

// ==== hdl/rst_sync_cell.sv ====
/*
 * Reset synchronizer: async assert, sync release,
 * scan reset bypass in test mode
 */
`include "core_ctrl_config.svh"

module rst_sync_cell
    import rst_pkg::*;
#(
    parameter int STAGES = `CORE_RST_SYNC_STAGES
) (
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  rst_test_s i_test,
    output logic      o_rst_n
);

    logic              arst_n;
    logic [STAGES-1:0] sync_ff;

    // Scan reset drives the chain in test mode
    assign arst_n = i_test.test_mode ? i_test.test_rst_n : i_arst_n;

    always_ff @(posedge i_clk, negedge arst_n)
    begin
        if (!arst_n)
            sync_ff <= '0;
        else
            sync_ff <= {sync_ff[STAGES-2:0], 1'b1};
    end

    assign o_rst_n = i_test.test_mode ? i_test.test_rst_n : sync_ff[STAGES-1];

endmodule : rst_sync_cell

// ==== list.f ====
+incdir+hdl
hdl/rst_pkg.sv
hdl/clk_pkg.sv
hdl/rst_sync_cell.sv
hdl/rst_buf_qlfy_cell.sv
hdl/rst_ctrl_unit.sv
hdl/clk_gate_ctrl.sv
hdl/core_ctrl_top.sv
tb/tb_core_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build the core reset and clock control testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_core_ctrl -f list.f -o sim_core_ctrl \
    && ./obj_dir/sim_core_ctrl | tee /dev/stderr | grep -qx "test passed" \
    && echo "Simulation OK" \
    || { echo "Simulation FAILED"; exit 1; }

// ==== tb/tb_core_ctrl.sv ====
/*
 * Testbench for the core reset and clock control block: reset release,
 * system/CPU reset, test mode and sleep/wake sequences checked every
 * cycle against a reference model, plus a watchdog
 */
`include "core_ctrl_config.svh"

module tb_core_ctrl
    import rst_pkg::*;
    import clk_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 8;
    // Synchronizer stages plus the buffer register
    localparam int REL_EDGES  = `CORE_RST_SYNC_STAGES + 1;
    localparam int MAX_CYC    = 1024;

    localparam int N_CPU_SYS   = 4;
    localparam int N_TEST_MODE = 16;
    localparam int N_STROBES   = 40;

    // Upper bounds of each test in clock cycles
    localparam int CYC_RELEASE   = RST_CYCLES + 4 * REL_EDGES + 8;
    localparam int CYC_CPU_SYS   = N_CPU_SYS * (4 * 5 + 4 * REL_EDGES + 2);
    localparam int CYC_TEST_MODE = N_TEST_MODE + 4 * REL_EDGES + 4;
    localparam int CYC_SLEEP     = 16;
    localparam int CYC_STROBES   = N_STROBES + 6;
    localparam int TIMEOUT_CYC   = CYC_RELEASE + CYC_CPU_SYS + CYC_TEST_MODE
                                   + CYC_SLEEP + CYC_STROBES + 50;

    logic       clk = 1'b0;
    logic       arst_n;
    rst_in_s    rst_in;
    rst_test_s  test_ctrl;
    clk_sleep_s sleep;
    core_rst_s  core_rst;
    logic       clk_pipe;
    logic       clk_pipe_en;

    integer seed;
    string  test_name;
    int     cyc = 0;
    int     pipe_edges = 0;
    logic   en_sampled = 1'b1;

    // Input history, one entry per clock cycle
    bit h_arst [MAX_CYC];
    bit h_rst  [MAX_CYC];
    bit h_cpu  [MAX_CYC];
    bit h_tm   [MAX_CYC];
    bit h_trst [MAX_CYC];
    bit h_sleep[MAX_CYC];
    bit h_wake [MAX_CYC];

    core_ctrl_top uut (
        .clk           (clk),
        .i_arst_n      (arst_n),
        .i_rst_in      (rst_in),
        .i_test        (test_ctrl),
        .i_sleep       (sleep),
        .o_core_rst    (core_rst),
        .o_clk_pipe    (clk_pipe),
        .o_clk_pipe_en (clk_pipe_en)
    );

    initial
    begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    // Cycles in a row, ending at c, with the reset released (capped)
    function automatic int run_len(input int c, input bit sys_only);
        int n;
        bit hi;
        n = 0;
        while (c - n >= 0 && n < REL_EDGES + 2)
        begin
            if (h_tm[c - n])
                hi = h_trst[c - n];
            else if (sys_only)
                hi = h_rst[c - n];
            else
                hi = h_arst[c - n] & h_rst[c - n] & h_cpu[c - n];
            if (!hi)
                break;
            n++;
        end
        return n;
    endfunction

    // Expected {core rst_n, qlfy, pipe clock enable} in cycle c
    function automatic logic [2:0] ref_ctrl(input int c);
        int   k;
        logic rst_n;
        logic qlfy;
        logic en;
        rst_n = run_len(c, 1'b0) > REL_EDGES;
        qlfy  = run_len(c, 1'b0) > REL_EDGES + 1;
        if (h_tm[c])
        begin
            rst_n = h_trst[c];
            qlfy  = h_trst[c];
        end
        // Walk back to the last system reset or strobe
        en = 1'b1;
        for (k = c; k > 0; k--)
        begin
            if (run_len(k, 1'b1) <= REL_EDGES || h_wake[k - 1])
                break;
            if (h_sleep[k - 1])
            begin
                en = 1'b0;
                break;
            end
        end
        return {rst_n, qlfy, en | h_tm[c]};
    endfunction

    // ------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------
    task automatic check_eq(input string name, input logic [31:0] expd,
                            input logic [31:0] act);
        if (expd !== act)
        begin
            $display("MISMATCH %s: expected %0h, actual %0h", name, expd, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin : compare_outputs
        logic [2:0] expd;
        if (cyc < MAX_CYC)
        begin
            h_arst[cyc]  = arst_n;
            h_rst[cyc]   = rst_in.rst_n;
            h_cpu[cyc]   = rst_in.cpu_rst_n;
            h_tm[cyc]    = test_ctrl.test_mode;
            h_trst[cyc]  = test_ctrl.test_rst_n;
            h_sleep[cyc] = sleep.sleep;
            h_wake[cyc]  = sleep.wake;
            expd = ref_ctrl(cyc);
            check_eq({test_name, " core rst_n"}, 32'(expd[2]), 32'(core_rst.rst_n));
            check_eq({test_name, " core qlfy"}, 32'(expd[1]), 32'(core_rst.qlfy));
            check_eq({test_name, " pipe clock enable"}, 32'(expd[0]), 32'(clk_pipe_en));
            en_sampled = clk_pipe_en;
            cyc++;
        end
    end

    // No gated clock edge may follow a cycle with the enable clear
    always @(posedge clk_pipe)
    begin
        pipe_edges++;
        check_eq({test_name, " gated clock edge"}, 1, 32'(en_sampled));
    end

    initial
    begin : watchdog
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
        $display("test failed");
        $fatal(1);
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------

    // Next drive point, just after a rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic int rand_cycles(input int lo, input int span);
        int r;
        r = $random(seed) & 32'h0000_00ff;
        return lo + r % span;
    endfunction

    // Count edges until the core reset and its qualifier rise
    task automatic wait_release(input string name);
        int n;
        int n_rst;
        int n_q;
        n     = 0;
        n_rst = -1;
        n_q   = -1;
        while (n_q < 0 && n < 4 * REL_EDGES)
        begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (n_rst < 0 && core_rst.rst_n)
                n_rst = n;
            if (core_rst.qlfy)
                n_q = n;
        end
        if (n_q < 0)
        begin
            $display("Core reset qualifier never rose after release in %s", name);
            $display("test failed");
            $fatal(1);
        end
        else
        begin
            check_eq({name, " edges to rst_n"}, REL_EDGES, n_rst);
            check_eq({name, " edges to qlfy"}, REL_EDGES + 1, n_q);
            step(1);
        end
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    initial
    begin : stimulus
        logic [31:0] r;
        int          e0;
        seed      = 24;
        test_name = "reset_release";
        arst_n    = 1'b0;
        rst_in    = '0;
        test_ctrl = '0;
        sleep     = '0;

        // System and CPU resets release while power-up reset is held
        step(2);
        rst_in = '{rst_n: 1'b1, cpu_rst_n: 1'b1};
        step(RST_CYCLES - 2);
        arst_n = 1'b1;
        wait_release("reset_release");
        step(4);

        test_name = "cpu_sys_reset";
        repeat (N_CPU_SYS)
        begin
            step(rand_cycles(1, 5));
            rst_in.cpu_rst_n = 1'b0;
            #1;
            check_eq("cpu_sys_reset drop rst_n", 0, 32'(core_rst.rst_n));
            check_eq("cpu_sys_reset drop qlfy", 0, 32'(core_rst.qlfy));
            step(rand_cycles(1, 5));
            rst_in.rst_n = 1'b0;
            step(rand_cycles(1, 5));
            rst_in.cpu_rst_n = 1'b1;
            step(rand_cycles(1, 5));
            rst_in.rst_n = 1'b1;
            wait_release("cpu_sys_reset");
        end

        // Scan reset overrides every other reset
        test_name = "test_mode";
        test_ctrl = '{test_mode: 1'b1, test_rst_n: 1'b0};
        repeat (N_TEST_MODE)
        begin
            r = $random(seed);
            test_ctrl.test_rst_n = r[0];
            arst_n               = r[1];
            rst_in.rst_n         = r[2];
            rst_in.cpu_rst_n     = r[3];
            #1;
            check_eq("test_mode rst_n", 32'(test_ctrl.test_rst_n), 32'(core_rst.rst_n));
            check_eq("test_mode enable", 1, 32'(clk_pipe_en));
            step(1);
        end
        test_ctrl.test_rst_n = 1'b0;
        arst_n = 1'b1;
        rst_in = '{rst_n: 1'b1, cpu_rst_n: 1'b1};
        step(1);
        test_ctrl.test_mode = 1'b0;
        wait_release("test_mode_exit");

        test_name = "sleep_wake";
        step(2);
        sleep.sleep = 1'b1;
        step(1);
        sleep.sleep = 1'b0;
        check_eq("sleep_wake enable after sleep", 0, 32'(clk_pipe_en));
        e0 = pipe_edges;
        step(5);
        check_eq("sleep_wake gated edges asleep", 0, pipe_edges - e0);
        sleep.wake = 1'b1;
        step(1);
        sleep.wake = 1'b0;
        check_eq("sleep_wake enable after wake", 1, 32'(clk_pipe_en));
        e0 = pipe_edges;
        step(4);
        check_eq("sleep_wake gated edges awake", 4, pipe_edges - e0);

        test_name = "random_strobes";
        repeat (N_STROBES)
        begin
            r = $random(seed);
            sleep.sleep = r[0];
            sleep.wake  = r[1];
            step(1);
            if (r[1])
                check_eq("random_strobes wake priority", 1, 32'(clk_pipe_en));
        end
        sleep = '0;
        step(3);

        $display("test passed");
        $finish;
    end

endmodule : tb_core_ctrl
